//--- fifo_pkg.sv
package fifo_pkg;

   // relation between the write and read port widths
   typedef enum logic [1:0] {
      ASYM_EQUAL  = 2'd0,
      ASYM_W_WIDE = 2'd1,
      ASYM_R_WIDE = 2'd2
   } asym_e;

   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // classify a pair of port widths
   function automatic asym_e asym_kind(input int w_data_w, input int r_data_w);
      asym_e kind;
      if (w_data_w > r_data_w) begin
         kind = ASYM_W_WIDE;
      end else if (r_data_w > w_data_w) begin
         kind = ASYM_R_WIDE;
      end else begin
         kind = ASYM_EQUAL;
      end
      return kind;
   endfunction

endpackage

//--- fifo_ram_2p.sv
`timescale 1ns/1ps

module fifo_ram_2p #(
   parameter int DATA_W = 8,
   parameter int LANES = 4,
   parameter int ADDR_W = 4
) (
   input  logic                    clk_i,
   input  logic [LANES-1:0]        w_en_i,
   input  logic [LANES-1:0]        r_en_i,
   input  logic [ADDR_W-1:0]       w_addr_i,
   input  logic [ADDR_W-1:0]       r_addr_i,
   input  logic [LANES*DATA_W-1:0] w_data_i,
   output logic [LANES*DATA_W-1:0] r_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   // one independent array per lane
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [DATA_W-1:0] mem [DEPTH];
      logic [DATA_W-1:0] rd_q;

      always_ff @(posedge clk_i) begin
         if (w_en_i[l]) begin
            mem[w_addr_i] <= w_data_i[l*DATA_W +: DATA_W];
         end
      end

      // registered read, lane output holds while not enabled
      always_ff @(posedge clk_i) begin
         if (r_en_i[l]) begin
            rd_q <= mem[r_addr_i];
         end
      end

      assign r_data_o[l*DATA_W +: DATA_W] = rd_q;
   end

endmodule

//--- fifo_level_ctrl.sv
`timescale 1ns/1ps

module fifo_level_ctrl
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W = 6,
   localparam int MAXDATA_W = max_w(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W = min_w(W_DATA_W, R_DATA_W),
   localparam int R = MAXDATA_W / MINDATA_W,
   localparam int MINADDR_W = ADDR_W - $clog2(R),
   localparam asym_e KIND = asym_kind(W_DATA_W, R_DATA_W),
   localparam int W_ADDR_W = (KIND == ASYM_W_WIDE) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W = (KIND == ASYM_R_WIDE) ? MINADDR_W : ADDR_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                w_en_i,
   input  logic                r_en_i,
   output logic                w_full_o,
   output logic                r_empty_o,
   output logic                w_acc_o,
   output logic                r_acc_o,
   output logic [W_ADDR_W-1:0] w_addr_o,
   output logic [R_ADDR_W-1:0] r_addr_o,
   output logic [ADDR_W:0]     level_o
);

   // level steps in narrow units, the wide side moves R at a time
   localparam logic [ADDR_W:0] W_INCR =
      (KIND == ASYM_W_WIDE) ? (ADDR_W+1)'(R) : (ADDR_W+1)'(1);
   localparam logic [ADDR_W:0] R_INCR =
      (KIND == ASYM_R_WIDE) ? (ADDR_W+1)'(R) : (ADDR_W+1)'(1);
   localparam logic [ADDR_W:0] CAPACITY = (ADDR_W+1)'(2 ** ADDR_W);
   localparam logic [ADDR_W:0] FULL_AT = CAPACITY - W_INCR;

   logic                w_acc;
   logic                r_acc;
   logic [W_ADDR_W-1:0] w_ptr_q;
   logic [R_ADDR_W-1:0] r_ptr_q;
   logic [ADDR_W:0]     level_q;
   logic [ADDR_W:0]     level_nxt;
   logic                full_q;
   logic                empty_q;

   // enables only count when the flags allow them
   assign w_acc = w_en_i & ~full_q;
   assign r_acc = r_en_i & ~empty_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
      end else begin
         if (w_acc) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (r_acc) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
      end
   end

   // both sides may act in the same cycle
   always_comb begin
      level_nxt = level_q;
      if (w_acc) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_acc) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   // flags follow the next level so they are valid right after the edge
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
         full_q  <= 1'b0;
         empty_q <= 1'b1;
      end else begin
         level_q <= level_nxt;
         full_q  <= level_nxt > FULL_AT;
         empty_q <= level_nxt < R_INCR;
      end
   end

   assign w_acc_o   = w_acc;
   assign r_acc_o   = r_acc;
   assign w_addr_o  = w_ptr_q;
   assign r_addr_o  = r_ptr_q;
   assign level_o   = level_q;
   assign w_full_o  = full_q;
   assign r_empty_o = empty_q;

endmodule

//--- fifo_asym_converter.sv
`timescale 1ns/1ps

module fifo_asym_converter
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W = 6,
   localparam int MAXDATA_W = max_w(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W = min_w(W_DATA_W, R_DATA_W),
   localparam int R = MAXDATA_W / MINDATA_W,
   localparam int LOG2_R = $clog2(R),
   localparam int MINADDR_W = ADDR_W - LOG2_R,
   localparam asym_e KIND = asym_kind(W_DATA_W, R_DATA_W),
   localparam int W_ADDR_W = (KIND == ASYM_W_WIDE) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W = (KIND == ASYM_R_WIDE) ? MINADDR_W : ADDR_W
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 w_acc_i,
   input  logic                 r_acc_i,
   input  logic [W_ADDR_W-1:0]  w_addr_i,
   input  logic [R_ADDR_W-1:0]  r_addr_i,
   input  logic [W_DATA_W-1:0]  w_data_i,
   output logic [R_DATA_W-1:0]  r_data_o,
   output logic [R-1:0]         ram_w_en_o,
   output logic [R-1:0]         ram_r_en_o,
   output logic [MINADDR_W-1:0] ram_w_addr_o,
   output logic [MINADDR_W-1:0] ram_r_addr_o,
   output logic [MAXDATA_W-1:0] ram_w_data_o,
   input  logic [MAXDATA_W-1:0] ram_r_data_i
);

   logic [R_DATA_W-1:0] r_data_sel;
   logic                r_valid_q;

   // write side
   if (KIND == ASYM_R_WIDE) begin : g_w_narrow
      // low pointer bits pick the lane, upper bits address it
      assign ram_w_en_o   = w_acc_i ? (R'(1) << w_addr_i[LOG2_R-1:0]) : '0;
      assign ram_w_addr_o = w_addr_i[ADDR_W-1:LOG2_R];
      // same unit on every lane, only the enabled one stores it
      assign ram_w_data_o = {R{w_data_i}};
   end else begin : g_w_wide
      // whole word across all lanes, lowest unit in lane 0
      assign ram_w_en_o   = {R{w_acc_i}};
      assign ram_w_addr_o = w_addr_i;
      assign ram_w_data_o = w_data_i;
   end

   // read side
   if (KIND == ASYM_W_WIDE) begin : g_r_narrow
      logic [LOG2_R-1:0] r_lane_q;

      assign ram_r_en_o   = r_acc_i ? (R'(1) << r_addr_i[LOG2_R-1:0]) : '0;
      assign ram_r_addr_o = r_addr_i[ADDR_W-1:LOG2_R];

      // lane select kept for the returning data, one cycle behind
      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            r_lane_q <= '0;
         end else if (r_acc_i) begin
            r_lane_q <= r_addr_i[LOG2_R-1:0];
         end
      end

      assign r_data_sel = ram_r_data_i[r_lane_q*MINDATA_W +: MINDATA_W];
   end else begin : g_r_wide
      // oldest unit ends up in the low bits
      assign ram_r_en_o   = {R{r_acc_i}};
      assign ram_r_addr_o = r_addr_i;
      assign r_data_sel   = ram_r_data_i;
   end

   // output stays at zero until the first read returns
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_valid_q <= 1'b0;
      end else if (r_acc_i) begin
         r_valid_q <= 1'b1;
      end
   end

   // held between reads since unread lanes keep their output
   assign r_data_o = r_valid_q ? r_data_sel : '0;

endmodule

//--- fifo_asym_top.sv
`timescale 1ns/1ps

module fifo_asym_top
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W = 6
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,
   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,
   output logic [ADDR_W:0]     level_o
);

   localparam int MAXDATA_W = max_w(W_DATA_W, R_DATA_W);
   localparam int MINDATA_W = min_w(W_DATA_W, R_DATA_W);
   localparam int R = MAXDATA_W / MINDATA_W;
   localparam int MINADDR_W = ADDR_W - $clog2(R);
   localparam asym_e KIND = asym_kind(W_DATA_W, R_DATA_W);
   localparam int W_ADDR_W = (KIND == ASYM_W_WIDE) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W = (KIND == ASYM_R_WIDE) ? MINADDR_W : ADDR_W;

   logic                 w_acc;
   logic                 r_acc;
   logic [W_ADDR_W-1:0]  w_addr;
   logic [R_ADDR_W-1:0]  r_addr;
   logic [R-1:0]         ram_w_en;
   logic [R-1:0]         ram_r_en;
   logic [MINADDR_W-1:0] ram_w_addr;
   logic [MINADDR_W-1:0] ram_r_addr;
   logic [MAXDATA_W-1:0] ram_w_data;
   logic [MAXDATA_W-1:0] ram_r_data;

   fifo_level_ctrl #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_ctrl (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en_i),
      .r_en_i   (r_en_i),
      .w_full_o (w_full_o),
      .r_empty_o(r_empty_o),
      .w_acc_o  (w_acc),
      .r_acc_o  (r_acc),
      .w_addr_o (w_addr),
      .r_addr_o (r_addr),
      .level_o  (level_o)
   );

   fifo_asym_converter #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_conv (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .w_acc_i     (w_acc),
      .r_acc_i     (r_acc),
      .w_addr_i    (w_addr),
      .r_addr_i    (r_addr),
      .w_data_i    (w_data_i),
      .r_data_o    (r_data_o),
      .ram_w_en_o  (ram_w_en),
      .ram_r_en_o  (ram_r_en),
      .ram_w_addr_o(ram_w_addr),
      .ram_r_addr_o(ram_r_addr),
      .ram_w_data_o(ram_w_data),
      .ram_r_data_i(ram_r_data)
   );

   // one lane per narrow unit of the wide side
   fifo_ram_2p #(
      .DATA_W(MINDATA_W),
      .LANES (R),
      .ADDR_W(MINADDR_W)
   ) u_ram (
      .clk_i   (clk_i),
      .w_en_i  (ram_w_en),
      .r_en_i  (ram_r_en),
      .w_addr_i(ram_w_addr),
      .r_addr_i(ram_r_addr),
      .w_data_i(ram_w_data),
      .r_data_o(ram_r_data)
   );

endmodule

//--- tb_fifo_asym.sv
`timescale 1ns/1ps

module tb_fifo_asym;

   logic        clk_i;
   logic        rst_n_i;
   logic        w_en_i;
   logic [31:0] w_data_i;
   logic        w_full_o;
   logic        r_en_i;
   logic [7:0]  r_data_o;
   logic        r_empty_o;
   logic [6:0]  level_o;

   logic [31:0] lfsr_q;
   logic [7:0]  model_q[$];
   logic [7:0]  exp_rdata;
   logic        chk_on;
   int          err_cnt;
   int          chk_cnt;
   int          test_base;
   int          tests_failed;
   int          n_both;

   fifo_asym_top #(
      .W_DATA_W(32),
      .R_DATA_W(8),
      .ADDR_W  (6)
   ) DUT (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en_i),
      .w_data_i (w_data_i),
      .w_full_o (w_full_o),
      .r_en_i   (r_en_i),
      .r_data_o (r_data_o),
      .r_empty_o(r_empty_o),
      .level_o  (level_o)
   );

   // galois lfsr stepped once per bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      end
      return val;
   endfunction

   // byte queue model where the read sees the state before this edge's write
   function automatic void apply_model(input logic w_en, input logic r_en,
                                       input logic [31:0] word);
      logic w_ok;
      logic r_ok;
      w_ok = w_en && (model_q.size() <= 60);
      r_ok = r_en && (model_q.size() != 0);
      if (r_ok) begin
         exp_rdata = model_q.pop_front();
      end
      // low byte goes out first
      if (w_ok) begin
         for (int b = 0; b < 4; b++) begin
            model_q.push_back(word[8*b +: 8]);
         end
      end
      if (w_ok && r_ok) begin
         n_both++;
      end
   endfunction

   task automatic check_value(input string what, input int got, input int exp);
      chk_cnt++;
      assert (got == exp) else begin
         $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic compare_outputs();
      check_value("level_o", level_o, model_q.size());
      check_value("w_full_o", w_full_o, model_q.size() > 60);
      check_value("r_empty_o", r_empty_o, model_q.size() == 0);
      check_value("r_data_o", r_data_o, exp_rdata);
   endtask

   task automatic report_test(input int num, input string name);
      if (err_cnt == test_base) begin
         $display("test %0d %s: pass", num, name);
      end else begin
         $display("test %0d %s: fail, %0d errors", num, name, err_cnt - test_base);
         tests_failed++;
      end
      test_base = err_cnt;
   endtask

   task automatic stop_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic settle();
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
   endtask

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // outputs checked at the falling edge after every rising edge
   always @(posedge clk_i) begin
      if (chk_on) begin
         apply_model(w_en_i, r_en_i, w_data_i);
         @(negedge clk_i);
         compare_outputs();
      end
   end

   initial begin
      int n;
      int hold;
      rst_n_i   = 1'b0;
      w_en_i    = 1'b0;
      r_en_i    = 1'b0;
      w_data_i  = '0;
      lfsr_q    = 32'h194f33fe;
      exp_rdata = '0;
      chk_on    = 1'b0;
      repeat (16) @(posedge clk_i);
      rst_n_i <= 1'b1;
      chk_on  <= 1'b1;
      @(negedge clk_i);
      check_value("level_o after reset", level_o, 0);
      check_value("r_empty_o after reset", r_empty_o, 1);
      check_value("w_full_o after reset", w_full_o, 0);
      report_test(1, "reset state");

      // fill with words until the full flag shows up
      n = 0;
      do begin
         @(posedge clk_i);
         w_en_i   <= 1'b1;
         w_data_i <= take_bits(32);
         @(negedge clk_i);
         n++;
         if (n > 40) begin
            stop_on_timeout("w_full_o");
         end
      end while (!w_full_o);
      @(posedge clk_i);
      w_en_i <= 1'b0;
      @(negedge clk_i);
      check_value("writes until full", n - 1, 16);
      check_value("level_o after write while full", level_o, 64);
      settle();
      report_test(2, "fill to full");

      // back-to-back reads until empty
      @(posedge clk_i);
      r_en_i <= 1'b1;
      n = 0;
      @(negedge clk_i);
      while (!r_empty_o) begin
         @(negedge clk_i);
         n++;
         if (n > 80) begin
            stop_on_timeout("r_empty_o");
         end
      end
      @(posedge clk_i);
      r_en_i <= 1'b0;
      check_value("reads until empty", n, 64);
      settle();
      report_test(3, "drain");

      hold = r_data_o;
      @(posedge clk_i);
      r_en_i <= 1'b1;
      repeat (3) @(posedge clk_i);
      r_en_i <= 1'b0;
      settle();
      check_value("level_o after read while empty", level_o, 0);
      check_value("r_data_o after read while empty", r_data_o, hold);
      report_test(4, "read while empty");

      // first half leans to filling and the second half to draining
      n_both = 0;
      for (int c = 0; c < 300; c++) begin
         @(posedge clk_i);
         if (c < 150) begin
            w_en_i <= take_bits(1) != 0;
            r_en_i <= take_bits(1) != 0;
         end else begin
            w_en_i <= take_bits(3) == 3'b111;
            r_en_i <= take_bits(2) != 0;
         end
         w_data_i <= take_bits(32);
      end
      @(posedge clk_i);
      w_en_i <= 1'b0;
      r_en_i <= 1'b0;
      settle();
      chk_cnt++;
      assert (n_both > 0) else begin
         $display("no write and read were ever accepted in the same cycle");
         err_cnt++;
      end
      report_test(5, "random traffic");

      $display("tests run 5, tests failed %0d, checks %0d, errors %0d",
               tests_failed, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- list.f
fifo_pkg.sv
fifo_ram_2p.sv
fifo_level_ctrl.sv
fifo_asym_converter.sv
fifo_asym_top.sv
tb_fifo_asym.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module tb_fifo_asym -o tb_fifo_asym
./obj_dir/tb_fifo_asym > sim.log 2>&1 || true
cat sim.log
if grep -qx "Result: PASSED" sim.log; then
   exit 0
else
   exit 1
fi
